// ==== sdi_reconfig.f ====
common/reconfig_pkg.sv
common/sdi_std_pkg.sv
channel/sdi_channel_slot.sv
src/reconfig_arbiter.sv
src/mif_word_sequencer.sv
src/sdi_reconfig_top.sv
verification/reconfig_checker.sv
verification/tb_sdi_reconfig.sv

// ==== verification/tb_sdi_reconfig.sv ====
// ========================================
// 24 random requests on 4 channels, seed 20
// requests held until done, then dropped
// ========================================
`timescale 1ns/1ps

module tb_sdi_reconfig;

   localparam int NUM_CHS       = 4;
   localparam int LAST_ROM_ADDR = 37;
   localparam int TOTAL_REQS    = 24;
   localparam int CLK_PERIOD    = 10;
   // up to 12 cycles per word, margin for arbitration and idle gaps
   localparam longint TIMEOUT_NS =
      longint'(TOTAL_REQS) * (LAST_ROM_ADDR + 1) * 12 * CLK_PERIOD + 50000;

   logic                 reconfig_clk;
   logic                 rst;
   logic [NUM_CHS-1:0]   reconfig_req;
   logic [2*NUM_CHS-1:0] rx_std;
   logic                 cfg_busy;
   logic                 cfg_write;
   logic [5:0]           cfg_addr;
   logic [15:0]          cfg_data;
   logic [1:0]           cfg_channel;
   logic [NUM_CHS-1:0]   reconfig_done;

   int     mismatch_count;
   int     protocol_count;
   int     stream_count;
   int     tb_errors;
   integer seed;
   int     issued;
   int     busy_left;
   // 0 idle, 1 wait for old done to clear, 2 wait for done, 3 hold
   int     ch_state [NUM_CHS];
   int     ch_count [NUM_CHS];

   function automatic int random_between(input int lo, input int hi);
      int r;
      r = $random(seed);
      if (r < 0) begin
         r = -r;
      end
      return lo + (r % (hi - lo + 1));
   endfunction

   function automatic logic all_idle();
      logic idle;
      idle = 1'b1;
      for (int i = 0; i < NUM_CHS; i++) begin
         if (ch_state[i] != 0) begin
            idle = 1'b0;
         end
      end
      return idle;
   endfunction

   // transceiver busy after each write, now and then before one
   task automatic drive_busy();
      if (cfg_write) begin
         busy_left = random_between(0, 5);
      end else if (busy_left == 0 && random_between(0, 15) == 0) begin
         busy_left = random_between(1, 3);
      end
      cfg_busy = (busy_left > 0);
      if (busy_left > 0) begin
         busy_left--;
      end
   endtask

   task automatic drive_requests();
      int pick;
      logic [NUM_CHS-1:0] subset;
      // sometimes a random group of idle channels asks together
      pick   = random_between(0, 7) == 0 ? random_between(0, 2**NUM_CHS - 1) : 0;
      subset = pick[NUM_CHS-1:0];
      for (int i = 0; i < NUM_CHS; i++) begin
         case (ch_state[i])
            0: begin
               if (ch_count[i] > 0) begin
                  ch_count[i]--;
               end else if (subset[i] && issued < TOTAL_REQS) begin
                  pick             = random_between(0, 3);
                  rx_std[2*i +: 2] = pick[1:0];
                  reconfig_req[i]  = 1'b1;
                  issued++;
                  ch_state[i] = 1;
               end
            end
            1: begin
               if (!reconfig_done[i]) begin
                  ch_state[i] = 2;
               end
            end
            2: begin
               if (reconfig_done[i]) begin
                  ch_state[i] = 3;
                  ch_count[i] = random_between(0, 10);
               end
            end
            default: begin
               // gap keeps the dropped level visible to the synchronizer
               if (ch_count[i] == 0) begin
                  reconfig_req[i] = 1'b0;
                  ch_state[i]     = 0;
                  ch_count[i]     = random_between(2, 5);
               end else begin
                  ch_count[i]--;
               end
            end
         endcase
      end
   endtask

   initial begin
      reconfig_clk = 1'b0;
      forever #(CLK_PERIOD / 2) reconfig_clk = ~reconfig_clk;
   end

   sdi_reconfig_top #(
      .NUM_CHS      (NUM_CHS),
      .LAST_ROM_ADDR(LAST_ROM_ADDR)
   ) u_sdi_reconfig_top (
      .reconfig_clk (reconfig_clk),
      .rst          (rst),
      .reconfig_req (reconfig_req),
      .rx_std       (rx_std),
      .cfg_busy     (cfg_busy),
      .cfg_write    (cfg_write),
      .cfg_addr     (cfg_addr),
      .cfg_data     (cfg_data),
      .cfg_channel  (cfg_channel),
      .reconfig_done(reconfig_done)
   );

   reconfig_checker #(
      .NUM_CHS      (NUM_CHS),
      .LAST_ROM_ADDR(LAST_ROM_ADDR)
   ) u_reconfig_checker (
      .reconfig_clk  (reconfig_clk),
      .rst           (rst),
      .reconfig_req  (reconfig_req),
      .rx_std        (rx_std),
      .cfg_busy      (cfg_busy),
      .cfg_write     (cfg_write),
      .cfg_addr      (cfg_addr),
      .cfg_data      (cfg_data),
      .cfg_channel   (cfg_channel),
      .reconfig_done (reconfig_done),
      .mismatch_count(mismatch_count),
      .protocol_count(protocol_count),
      .stream_count  (stream_count)
   );

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns, %0d of %0d requests issued, %0d streams done",
               TIMEOUT_NS, issued, TOTAL_REQS, stream_count);
      $display("Errors: %0d mismatch, %0d protocol, %0d testbench",
               mismatch_count, protocol_count, tb_errors + 1);
      $display("Verification failed");
      $finish;
   end

   initial begin
      seed         = 20;
      rst          = 1'b1;
      reconfig_req = '0;
      rx_std       = '0;
      cfg_busy     = 1'b0;
      issued       = 0;
      busy_left    = 0;
      tb_errors    = 0;
      for (int i = 0; i < NUM_CHS; i++) begin
         ch_state[i] = 0;
         ch_count[i] = 0;
      end
      repeat (4) @(posedge reconfig_clk);
      #1 rst = 1'b0;
      // quiet stretch after reset, the checker flags any stray write
      repeat (6) @(posedge reconfig_clk);
      while (issued < TOTAL_REQS || !all_idle()) begin
         @(posedge reconfig_clk);
         #1;
         drive_busy();
         drive_requests();
      end
      repeat (10) @(posedge reconfig_clk);
      if (stream_count != TOTAL_REQS) begin
         $display("Error: %0d complete streams seen for %0d requests",
                  stream_count, TOTAL_REQS);
         tb_errors++;
      end
      $display("Errors: %0d mismatch, %0d protocol, %0d testbench",
               mismatch_count, protocol_count, tb_errors);
      if (mismatch_count == 0 && protocol_count == 0 && tb_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== verification/reconfig_checker.sv ====
// ========================================
// cycle model of arbiter, word stream and done flags
// assumes rx_std stays stable while its request is high
// ========================================
`timescale 1ns/1ps

module reconfig_checker #(
   parameter int NUM_CHS       = 4,
   parameter int LAST_ROM_ADDR = 37
) (
   input  logic                 reconfig_clk,
   input  logic                 rst,
   input  logic [NUM_CHS-1:0]   reconfig_req,
   input  logic [2*NUM_CHS-1:0] rx_std,
   input  logic                 cfg_busy,
   input  logic                 cfg_write,
   input  logic [5:0]           cfg_addr,
   input  logic [15:0]          cfg_data,
   input  logic [1:0]           cfg_channel,
   input  logic [NUM_CHS-1:0]   reconfig_done,
   output int                   mismatch_count,
   output int                   protocol_count,
   output int                   stream_count
);

   // receive divider word and its HD value
   localparam int         HD_ADDR = 29;
   localparam logic [3:0] HD_DIV  = 4'b0011;

   // request after the two-flop synchronizer
   logic [NUM_CHS-1:0] req_d1;
   logic [NUM_CHS-1:0] req_d2;
   logic [NUM_CHS-1:0] done_m;
   logic               serving;
   logic               words_done;
   logic               busy_d;
   int                 exp_ch;
   int                 exp_addr;

   // 1010, channel, address, 0101, HD divider patched into word 29
   function automatic logic [15:0] expected_word(input int ch, input int addr,
                                                 input logic [1:0] std);
      logic [15:0] w;
      w = {4'b1010, ch[1:0], addr[5:0], 4'b0101};
      if (std == 2'b01 && addr == HD_ADDR) begin
         w[3:0] = HD_DIV;
      end
      return w;
   endfunction

   initial begin
      mismatch_count = 0;
      protocol_count = 0;
      stream_count   = 0;
   end

   always @(posedge reconfig_clk or posedge rst) begin : model
      logic [15:0] exp_data;
      if (rst) begin
         req_d1     = '0;
         req_d2     = '0;
         done_m     = '0;
         serving    = 1'b0;
         words_done = 1'b0;
         busy_d     = 1'b0;
         exp_ch     = 0;
         exp_addr   = 0;
      end else begin
         // all DUT values here are the ones before this edge
         if (reconfig_done !== done_m) begin
            $display("Mismatch at %0d ns: reconfig_done expected %b actual %b",
                     $time, done_m, reconfig_done);
            mismatch_count++;
         end
         // served channel is marked done each cycle after its last word
         for (int i = 0; i < NUM_CHS; i++) begin
            if (serving && words_done && exp_ch == i) begin
               done_m[i] = 1'b1;
            end else if (req_d2[i]) begin
               done_m[i] = 1'b0;
            end
         end
         // free arbiter takes the lowest pending channel
         if (!serving && |req_d2) begin
            exp_ch = NUM_CHS;
            for (int i = NUM_CHS - 1; i >= 0; i--) begin
               if (req_d2[i]) begin
                  exp_ch = i;
               end
            end
            serving    = 1'b1;
            words_done = 1'b0;
            exp_addr   = 0;
         end else if (serving && words_done && !req_d2[exp_ch]) begin
            serving = 1'b0;
         end
         if ($isunknown(cfg_write)) begin
            $display("Error at %0d ns: cfg_write is unknown", $time);
            protocol_count++;
         end
         if (cfg_write === 1'b1 && busy_d) begin
            $display("Error at %0d ns: write issued right after a busy cycle", $time);
            protocol_count++;
         end
         if (cfg_write === 1'b1 && (!serving || words_done)) begin
            $display("Error at %0d ns: write while no channel stream is open", $time);
            protocol_count++;
         end else if (cfg_write === 1'b1) begin
            exp_data = expected_word(exp_ch, exp_addr, rx_std[2*exp_ch +: 2]);
            if (cfg_channel !== exp_ch[1:0]) begin
               $display("Mismatch at %0d ns: cfg_channel expected %0d actual %0d",
                        $time, exp_ch, cfg_channel);
               mismatch_count++;
            end
            if (cfg_addr !== exp_addr[5:0]) begin
               $display("Mismatch at %0d ns: cfg_addr expected %0d actual %0d",
                        $time, exp_addr, cfg_addr);
               mismatch_count++;
            end
            if (cfg_data !== exp_data) begin
               $display("Mismatch at %0d ns: cfg_data expected %h actual %h",
                        $time, exp_data, cfg_data);
               mismatch_count++;
            end
            if (exp_addr == LAST_ROM_ADDR) begin
               words_done = 1'b1;
               stream_count++;
            end else begin
               exp_addr++;
            end
         end
         busy_d = cfg_busy;
         req_d2 = req_d1;
         req_d1 = reconfig_req;
      end
   end

endmodule

// ==== src/sdi_reconfig_top.sv ====
// ========================================
// NUM_CHS from 1 to 4, rx_std held while its req is high
// cfg_addr, cfg_data, cfg_channel valid with cfg_write
// ========================================
`timescale 1ns/1ps

module sdi_reconfig_top #(
   parameter int NUM_CHS       = 4,
   parameter int LAST_ROM_ADDR = 37
) (
   input  logic                                              reconfig_clk,
   input  logic                                              rst,
   input  logic [NUM_CHS-1:0]                                reconfig_req,
   input  logic [NUM_CHS*$bits(sdi_std_pkg::sdi_std_t)-1:0]  rx_std,
   input  logic                                              cfg_busy,
   output logic                                              cfg_write,
   output reconfig_pkg::rom_addr_t                           cfg_addr,
   output reconfig_pkg::cfg_word_t                           cfg_data,
   output reconfig_pkg::ch_idx_t                             cfg_channel,
   output logic [NUM_CHS-1:0]                                reconfig_done
);

   import reconfig_pkg::*;
   import sdi_std_pkg::*;

   localparam int WORD_W = $bits(cfg_word_t);

   // channel index is 2 bits wide
   if (NUM_CHS < 1 || NUM_CHS > 4) begin : g_bad_num_chs
      $error("NUM_CHS must be 1 to 4");
   end

   // sequencer to slots
   rom_addr_t rom_addr;
   logic      rom_en;

   // slots to arbiter
   logic [NUM_CHS-1:0]        req_sync;
   logic [NUM_CHS*WORD_W-1:0] image_words;

   // arbiter to slots and sequencer
   logic [NUM_CHS-1:0] set_done;
   logic               seq_start;
   logic               seq_active;
   ch_idx_t            sel_ch;
   cfg_word_t          sel_word;
   sdi_std_t           sel_std;

   mif_word_sequencer #(
      .LAST_ROM_ADDR(LAST_ROM_ADDR)
   ) u_mif_word_sequencer (
      .reconfig_clk(reconfig_clk),
      .rst         (rst),
      .seq_start   (seq_start),
      .sel_word    (sel_word),
      .sel_std     (sel_std),
      .sel_ch      (sel_ch),
      .cfg_busy    (cfg_busy),
      .rom_addr    (rom_addr),
      .rom_en      (rom_en),
      .seq_active  (seq_active),
      .cfg_write   (cfg_write),
      .cfg_addr    (cfg_addr),
      .cfg_data    (cfg_data),
      .cfg_channel (cfg_channel)
   );

   // one slot per channel, all share the address bus
   for (genvar g = 0; g < NUM_CHS; g++) begin : g_slot
      sdi_channel_slot #(
         .CH_INDEX(g)
      ) u_sdi_channel_slot (
         .reconfig_clk(reconfig_clk),
         .rst         (rst),
         .req         (reconfig_req[g]),
         .rom_addr    (rom_addr),
         .rom_en      (rom_en),
         .set_done    (set_done[g]),
         .req_sync    (req_sync[g]),
         .image_word  (image_words[g*WORD_W +: WORD_W]),
         .done        (reconfig_done[g])
      );
   end

   reconfig_arbiter #(
      .NUM_CHS(NUM_CHS)
   ) u_reconfig_arbiter (
      .reconfig_clk(reconfig_clk),
      .rst         (rst),
      .req_sync    (req_sync),
      .image_words (image_words),
      .rx_std      (rx_std),
      .seq_active  (seq_active),
      .seq_start   (seq_start),
      .set_done    (set_done),
      .sel_ch      (sel_ch),
      .sel_word    (sel_word),
      .sel_std     (sel_std)
   );

endmodule

// ==== src/mif_word_sequencer.sv ====
// ========================================
// 4 cycles per word without busy, longer with it
// cfg_busy is only honoured between words
// ========================================
`timescale 1ns/1ps

module mif_word_sequencer #(
   parameter int LAST_ROM_ADDR = 37
) (
   input  logic                    reconfig_clk,
   input  logic                    rst,
   input  logic                    seq_start,
   input  reconfig_pkg::cfg_word_t sel_word,
   input  sdi_std_pkg::sdi_std_t   sel_std,
   input  reconfig_pkg::ch_idx_t   sel_ch,
   input  logic                    cfg_busy,
   output reconfig_pkg::rom_addr_t rom_addr,
   output logic                    rom_en,
   output logic                    seq_active,
   output logic                    cfg_write,
   output reconfig_pkg::rom_addr_t cfg_addr,
   output reconfig_pkg::cfg_word_t cfg_data,
   output reconfig_pkg::ch_idx_t   cfg_channel
);

   import reconfig_pkg::*;
   import sdi_std_pkg::*;

   seq_state_t state;

   // second settle cycle marker
   logic settle_cnt;

   // word to write, after the HD patch
   cfg_word_t out_word;

   // last settle cycle with busy still low
   logic write_go;

   // divider word of an HD channel
   logic hd_patch;

   assign hd_patch = is_hd(sel_std) && (rom_addr == rom_addr_t'(HD_PATCH_ADDR));

   always_comb begin
      out_word = sel_word;
      if (hd_patch) begin
         out_word[3:0] = RCRU_M_HD;
      end
   end

   // busy seen at this edge aborts the write, so a write
   // never follows a busy cycle
   assign write_go = (state == SEQ_SETTLE) && settle_cnt && !cfg_busy;

   always_ff @(posedge reconfig_clk or posedge rst) begin
      if (rst) begin
         state      <= SEQ_IDLE;
         rom_addr   <= '0;
         settle_cnt <= 1'b0;
         cfg_write  <= 1'b0;
      end else begin
         cfg_write <= 1'b0;
         case (state)
            SEQ_IDLE: begin
               if (seq_start) begin
                  rom_addr <= '0;
                  state    <= SEQ_WAIT;
               end
            end
            SEQ_WAIT: begin
               // stay until the transceiver is free
               settle_cnt <= 1'b0;
               if (!cfg_busy) begin
                  state <= SEQ_SETTLE;
               end
            end
            SEQ_SETTLE: begin
               // first cycle loads the ROM, second lets the mux settle
               if (cfg_busy) begin
                  state <= SEQ_WAIT;
               end else if (settle_cnt) begin
                  cfg_write <= 1'b1;
                  state     <= SEQ_NEXT;
               end else begin
                  settle_cnt <= 1'b1;
               end
            end
            SEQ_NEXT: begin
               // write pulse is on the bus during this cycle
               if (rom_addr == rom_addr_t'(LAST_ROM_ADDR)) begin
                  state <= SEQ_IDLE;
               end else begin
                  rom_addr <= rom_addr + rom_addr_t'(1);
                  state    <= SEQ_WAIT;
               end
            end
            default: begin
               state <= SEQ_IDLE;
            end
         endcase
      end
   end

   // write payload, only meaningful with cfg_write
   always_ff @(posedge reconfig_clk) begin
      if (write_go) begin
         cfg_addr    <= rom_addr;
         cfg_data    <= out_word;
         cfg_channel <= sel_ch;
      end
   end

   assign rom_en     = (state == SEQ_SETTLE);
   assign seq_active = (state != SEQ_IDLE);

   a_no_write_after_busy : assert property (
      @(posedge reconfig_clk) disable iff (rst)
      cfg_write |-> !$past(cfg_busy)
   ) else $error("cfg_write issued right after a busy cycle");

   a_addr_in_range : assert property (
      @(posedge reconfig_clk) disable iff (rst)
      cfg_write |-> (cfg_addr <= rom_addr_t'(LAST_ROM_ADDR))
   ) else $error("cfg_addr %0d beyond last image word", cfg_addr);

endmodule

// ==== src/reconfig_arbiter.sv ====
// ========================================
// fixed priority, channel 0 first, no round robin
// a served request must drop before the next start
// ========================================
`timescale 1ns/1ps

module reconfig_arbiter #(
   parameter int NUM_CHS = 4
) (
   input  logic                                        reconfig_clk,
   input  logic                                        rst,
   input  logic [NUM_CHS-1:0]                          req_sync,
   input  logic [NUM_CHS*$bits(reconfig_pkg::cfg_word_t)-1:0] image_words,
   input  logic [NUM_CHS*$bits(sdi_std_pkg::sdi_std_t)-1:0]   rx_std,
   input  logic                                        seq_active,
   output logic                                        seq_start,
   output logic [NUM_CHS-1:0]                          set_done,
   output reconfig_pkg::ch_idx_t                       sel_ch,
   output reconfig_pkg::cfg_word_t                     sel_word,
   output sdi_std_pkg::sdi_std_t                       sel_std
);

   import reconfig_pkg::*;
   import sdi_std_pkg::*;

   localparam int WORD_W = $bits(cfg_word_t);
   localparam int STD_W  = $bits(sdi_std_t);

   arb_state_t state;

   // lowest requesting channel this cycle
   ch_idx_t low_ch;

   // any channel waiting
   logic any_req;

   // stream of the served channel has ended
   logic stream_end;

   // scan from the top so the lowest index wins
   always_comb begin
      low_ch = '0;
      for (int i = NUM_CHS - 1; i >= 0; i--) begin
         if (req_sync[i]) begin
            low_ch = ch_idx_t'(i);
         end
      end
   end

   assign any_req = |req_sync;

   // seq_active is already high in the first ARB_SERVE cycle,
   // so its low level there means the stream is over
   assign stream_end = (state == ARB_SERVE) && !seq_active;

   always_ff @(posedge reconfig_clk or posedge rst) begin
      if (rst) begin
         state  <= ARB_IDLE;
         sel_ch <= '0;
      end else begin
         case (state)
            ARB_IDLE: begin
               // latch the winner, it stays fixed until served
               if (any_req) begin
                  sel_ch <= low_ch;
                  state  <= ARB_START;
               end
            end
            ARB_START: begin
               state <= ARB_SERVE;
            end
            ARB_SERVE: begin
               // hold here until the served request is withdrawn
               if (stream_end && !req_sync[sel_ch]) begin
                  state <= ARB_IDLE;
               end
            end
            default: begin
               state <= ARB_IDLE;
            end
         endcase
      end
   end

   // one cycle start, the only cycle spent in ARB_START
   assign seq_start = (state == ARB_START);

   // done is re-asserted every cycle after the stream,
   // otherwise the slot would clear it again while req is high
   always_comb begin
      set_done = '0;
      if (stream_end) begin
         set_done[sel_ch] = 1'b1;
      end
   end

   // image word and standard of the served channel
   assign sel_word = image_words[sel_ch*WORD_W +: WORD_W];
   assign sel_std  = rx_std[sel_ch*STD_W +: STD_W];

   a_set_done_onehot : assert property (
      @(posedge reconfig_clk) disable iff (rst)
      $onehot0(set_done)
   ) else $error("set_done marks more than one channel");

   // sequencer must pick up the start on the very next edge
   a_start_taken : assert property (
      @(posedge reconfig_clk) disable iff (rst)
      seq_start |=> seq_active
   ) else $error("sequencer did not go active after seq_start");

endmodule

// ==== channel/sdi_channel_slot.sv ====
// ========================================
// req is asynchronous, reaches req_sync 2 cycles later
// image_word is valid 1 cycle after rom_en
// ========================================
`timescale 1ns/1ps

module sdi_channel_slot #(
   parameter int CH_INDEX = 0
) (
   input  logic                  reconfig_clk,
   input  logic                  rst,
   input  logic                  req,
   input  reconfig_pkg::rom_addr_t rom_addr,
   input  logic                  rom_en,
   input  logic                  set_done,
   output logic                  req_sync,
   output reconfig_pkg::cfg_word_t image_word,
   output logic                  done
);

   import reconfig_pkg::*;

   // full address range, unused tail words are never read
   localparam int ROM_DEPTH = 2 ** $bits(rom_addr_t);

   // channel index as seen in the image words
   localparam ch_idx_t SLOT_CH = ch_idx_t'(CH_INDEX);

   // two-flop synchronizer for the request level
   logic [1:0] req_meta;

   // constant image, one entry per address
   cfg_word_t rom_mem [ROM_DEPTH];

   always_ff @(posedge reconfig_clk or posedge rst) begin
      if (rst) begin
         req_meta <= 2'b00;
      end else begin
         req_meta <= {req_meta[0], req};
      end
   end

   assign req_sync = req_meta[1];

   // fill the image from the shared word rule
   for (genvar a = 0; a < ROM_DEPTH; a++) begin : g_rom
      assign rom_mem[a] = rom_word_fn(SLOT_CH, rom_addr_t'(a));
   end

   // registered read port
   // output holds while rom_en is low
   always_ff @(posedge reconfig_clk) begin
      if (rom_en) begin
         image_word <= rom_mem[rom_addr];
      end
   end

   // done flag
   // set wins over clear so the flag rises while the request is held,
   // a held request without set_done keeps it low, idle channel holds it
   always_ff @(posedge reconfig_clk or posedge rst) begin
      if (rst) begin
         done <= 1'b0;
      end else if (set_done) begin
         done <= 1'b1;
      end else if (req_sync) begin
         done <= 1'b0;
      end
   end

   // the arbiter only marks a channel done that asked for service
   // req_sync may already be low in the last set cycle
   a_done_after_req : assert property (
      @(posedge reconfig_clk) disable iff (rst)
      $rose(set_done) |-> $past(req_sync, 1) || req_sync
   ) else $error("slot %0d marked done without a request", CH_INDEX);

endmodule

// ==== common/sdi_std_pkg.sv ====
// ========================================
// standard codes as seen on rx_std
// the HD patch only touches the low nibble of one word
// ========================================
package sdi_std_pkg;

   // receive standard per channel
   typedef logic [1:0] sdi_std_t;

   // 3G shows up as either 10 or 11
   localparam sdi_std_t SDI_STD_SD  = 2'b00;
   localparam sdi_std_t SDI_STD_HD  = 2'b01;
   localparam sdi_std_t SDI_STD_3G  = 2'b10;
   localparam sdi_std_t SDI_STD_3GB = 2'b11;

   // image word holding the receive clock divider
   localparam int unsigned HD_PATCH_ADDR = 29;

   // divider field written for HD
   // ROM images carry the 3G/SD value
   localparam logic [3:0] RCRU_M_HD = 4'b0011;

   // only the exact HD code gets the patch
   function automatic logic is_hd(input sdi_std_t std);
      return (std == SDI_STD_HD);
   endfunction

endpackage

// ==== common/reconfig_pkg.sv ====
// ========================================
// image words are 16 bits at up to 64 addresses
// channel index is 2 bits, so at most four channels
// ========================================
package reconfig_pkg;

   // image word address into the per-channel ROM
   typedef logic [5:0] rom_addr_t;

   // one transceiver configuration word
   typedef logic [15:0] cfg_word_t;

   // logical channel index on the reconfiguration port
   typedef logic [1:0] ch_idx_t;

   // arbiter FSM
   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_START,
      ARB_SERVE
   } arb_state_t;

   // word sequencer FSM
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_WAIT,
      SEQ_SETTLE,
      SEQ_NEXT
   } seq_state_t;

   // image contents, same rule for every channel ROM
   // 1010 | channel | address | 0101
   function automatic cfg_word_t rom_word_fn(input ch_idx_t ch, input rom_addr_t addr);
      cfg_word_t word;
      word = {4'b1010, ch, addr, 4'b0101};
      return word;
   endfunction

endpackage
